/* all.f */
qrd_ctrl_pkg.sv
qrd_num_pkg.sv
qrd_ctrl.sv
qrd_cordic.sv
qrd_vector_cell.sv
qrd_rotate_cell.sv
qrd_top.sv
qrd_chk.sv
tb_qrd.sv

/* qrd_chk.sv */
`default_nettype none

module qrd_chk (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic row_valid_i,
    input wire logic in_ready_i,
    input wire logic out_valid_i
);

    // One ready pulse per frame
    property ready_period_p;
        @(posedge clk) disable iff (!rst_n)
            in_ready_i |=> !in_ready_i [*(qrd_ctrl_pkg::FRAME_LEN - 1)] ##1 in_ready_i;
    endproperty

    // Result only for a flagged job taken two frames back
    property valid_with_ready_p;
        @(posedge clk) disable iff (!rst_n)
            out_valid_i |-> in_ready_i
                && $past(in_ready_i && row_valid_i, 2 * qrd_ctrl_pkg::FRAME_LEN);
    endproperty

    // Synchronous reset clears both strobes
    property quiet_in_reset_p;
        @(posedge clk) !rst_n |=> (!in_ready_i && !out_valid_i);
    endproperty

    ready_period_a: assert property (ready_period_p)
        else $error("in_ready_o does not pulse once per frame");
    valid_with_ready_a: assert property (valid_with_ready_p)
        else $error("out_valid_o high without a flagged job two frames earlier");
    quiet_in_reset_a: assert property (quiet_in_reset_p)
        else $error("Strobe high during reset");

endmodule

bind qrd_top qrd_chk u_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .row_valid_i (row_valid_i),
    .in_ready_i  (in_ready_o),
    .out_valid_i (out_valid_o)
);

`default_nettype wire

/* qrd_cordic.sv */
`default_nettype none

module qrd_cordic #(
    parameter bit VECTORING = 1'b1
) (
    input  logic                 clk,
    input  logic                 load_i,
    input  logic                 gain_i,
    input  qrd_ctrl_pkg::iter_t  iter_i,
    input  qrd_num_pkg::sample_t x_i,
    input  qrd_num_pkg::sample_t y_i,
    input  qrd_num_pkg::sample_t z_i,
    output qrd_num_pkg::sample_t x_o,
    output qrd_num_pkg::sample_t y_o,
    output qrd_num_pkg::sample_t z_o
);

    qrd_num_pkg::sample_t x_r;
    qrd_num_pkg::sample_t y_r;
    qrd_num_pkg::sample_t z_r;
    logic                 inv_r;  // Angle was folded, flip x and y at gain

    qrd_num_pkg::sample_t x_ld;
    qrd_num_pkg::sample_t y_ld;
    qrd_num_pkg::sample_t z_ld;
    logic                 inv_ld;

    qrd_num_pkg::sample_t x_sft;
    qrd_num_pkg::sample_t y_sft;
    qrd_num_pkg::sample_t dz;
    logic                 dir;
    logic                 update;

    logic signed [2*qrd_num_pkg::WIDTH-1:0] x_prod;
    logic signed [2*qrd_num_pkg::WIDTH-1:0] y_prod;
    qrd_num_pkg::sample_t                   x_gain;
    qrd_num_pkg::sample_t                   y_gain;

    // Range correction at load
    always_comb begin
        x_ld   = x_i;
        y_ld   = y_i;
        z_ld   = z_i;
        inv_ld = 1'b0;
        if (VECTORING) begin
            if (x_i < 0) begin  // Left half plane, pre-rotate by pi
                x_ld = -x_i;
                y_ld = -y_i;
                z_ld = (y_i >= 0) ? qrd_num_pkg::PI_Q : -qrd_num_pkg::PI_Q;
            end
        end else if (z_i > qrd_num_pkg::FOLD_LIMIT) begin
            z_ld   = z_i - qrd_num_pkg::PI_Q;
            inv_ld = 1'b1;
        end else if (z_i < -qrd_num_pkg::FOLD_LIMIT - 1) begin
            z_ld   = z_i + qrd_num_pkg::PI_Q;
            inv_ld = 1'b1;
        end
    end

    // Direction of the current micro-rotation
    always_comb begin
        x_sft = x_r >>> iter_i;
        y_sft = y_r >>> iter_i;
        dz    = qrd_num_pkg::ATAN_TAB[iter_i];
        if (VECTORING) begin
            dir    = (y_r > 0);
            update = (y_r != 0);  // Already on the axis
        end else begin
            dir    = (z_r < 0);
            update = (z_r != 0);
        end
    end

    // Gain compensation, Q.10 product scaled back
    assign x_prod = x_r * qrd_num_pkg::GAIN_K;
    assign y_prod = y_r * qrd_num_pkg::GAIN_K;
    assign x_gain = x_prod[qrd_num_pkg::FRAC_BITS +: qrd_num_pkg::WIDTH];
    assign y_gain = y_prod[qrd_num_pkg::FRAC_BITS +: qrd_num_pkg::WIDTH];

    always_ff @(posedge clk) begin
        if (load_i) begin
            x_r   <= x_ld;
            y_r   <= y_ld;
            z_r   <= z_ld;
            inv_r <= inv_ld;
        end else if (gain_i) begin
            x_r <= inv_r ? -x_gain : x_gain;
            y_r <= inv_r ? -y_gain : y_gain;
        end else if (update) begin
            if (dir) begin
                x_r <= x_r + y_sft;
                y_r <= y_r - x_sft;
                z_r <= z_r + dz;
            end else begin
                x_r <= x_r - y_sft;
                y_r <= y_r + x_sft;
                z_r <= z_r - dz;
            end
        end
    end

    assign x_o = x_r;
    assign y_o = y_r;
    assign z_o = z_r;

endmodule

`default_nettype wire

/* qrd_ctrl.sv */
`default_nettype none

module qrd_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    output logic                load_o,
    output qrd_ctrl_pkg::iter_t iter_o,
    output logic                gain_o
);

    // Counter runs one cycle ahead of the registered strobes
    logic [$clog2(qrd_ctrl_pkg::FRAME_LEN)-1:0] cnt_r;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_r  <= '0;
            load_o <= 1'b0;
            gain_o <= 1'b0;
            iter_o <= '0;
        end else begin
            if (cnt_r == qrd_ctrl_pkg::FRAME_LEN - 1) begin
                cnt_r <= '0;
            end else begin
                cnt_r <= cnt_r + 1'b1;
            end

            load_o <= (cnt_r == 0);
            gain_o <= (cnt_r == qrd_ctrl_pkg::FRAME_LEN - 1);

            if (cnt_r >= 1 && cnt_r <= qrd_ctrl_pkg::NUM_ITER) begin
                iter_o <= qrd_ctrl_pkg::iter_t'(cnt_r - 1'b1);
            end else begin
                iter_o <= '0;  // Idle index outside the iterations
            end
        end
    end

endmodule

`default_nettype wire

/* qrd_ctrl_pkg.sv */
`default_nettype none

package qrd_ctrl_pkg;

    localparam int NUM_ITER = 12;

    // One load cycle, the micro-rotations, one gain cycle
    localparam int FRAME_LEN = NUM_ITER + 2;

    typedef logic [3:0] iter_t;

endpackage

`default_nettype wire

/* qrd_num_pkg.sv */
`default_nettype none

package qrd_num_pkg;

    // Samples and angles share one Q3.10 format
    localparam int WIDTH     = 14;
    localparam int FRAC_BITS = 10;

    typedef logic signed [WIDTH-1:0] sample_t;

    localparam sample_t PI_Q       = 14'sd3216;
    localparam sample_t FOLD_LIMIT = 14'sd1785;  // About 1.743 rad
    localparam sample_t GAIN_K     = 14'sd622;   // 1/1.6468 in Q.10

    // atan(2^-i), one entry per micro-rotation
    localparam sample_t ATAN_TAB [qrd_ctrl_pkg::NUM_ITER] = '{
        14'sd804,
        14'sd475,
        14'sd251,
        14'sd127,
        14'sd64,
        14'sd32,
        14'sd16,
        14'sd8,
        14'sd4,
        14'sd2,
        14'sd1,
        14'sd0
    };

endpackage

`default_nettype wire

/* qrd_rotate_cell.sv */
`default_nettype none

module qrd_rotate_cell (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load_i,
    input  logic                 gain_i,
    input  qrd_ctrl_pkg::iter_t  iter_i,
    input  qrd_num_pkg::sample_t mag_i,
    input  qrd_num_pkg::sample_t angle_i,
    input  qrd_num_pkg::sample_t x_i,
    input  qrd_num_pkg::sample_t y_i,
    input  logic                 valid_i,
    output qrd_num_pkg::sample_t r00_o,
    output qrd_num_pkg::sample_t r01_o,
    output qrd_num_pkg::sample_t r11_o,
    output logic                 out_valid_o
);

    qrd_num_pkg::sample_t mag_r;  // r00 travels beside the rotation
    logic                 flag_r;

    qrd_cordic #(
        .VECTORING (1'b0)
    ) u_cordic (
        .clk    (clk),
        .load_i (load_i),
        .gain_i (gain_i),
        .iter_i (iter_i),
        .x_i    (x_i),
        .y_i    (y_i),
        .z_i    (angle_i),
        .x_o    (r01_o),
        .y_o    (r11_o),
        .z_o    ()
    );

    always_ff @(posedge clk) begin
        if (load_i) begin
            mag_r <= mag_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flag_r <= 1'b0;
        end else if (load_i) begin
            flag_r <= valid_i;
        end
    end

    // Result is complete once the next frame starts
    assign out_valid_o = load_i & flag_r;
    assign r00_o       = mag_r;

endmodule

`default_nettype wire

/* qrd_top.sv */
`default_nettype none

module qrd_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  qrd_num_pkg::sample_t a0_i,
    input  qrd_num_pkg::sample_t a1_i,
    input  qrd_num_pkg::sample_t b0_i,
    input  qrd_num_pkg::sample_t b1_i,
    input  logic                 row_valid_i,
    output logic                 in_ready_o,
    output logic                 out_valid_o,
    output qrd_num_pkg::sample_t r00_o,
    output qrd_num_pkg::sample_t r01_o,
    output qrd_num_pkg::sample_t r11_o
);

    logic                 load;
    logic                 gain;
    qrd_ctrl_pkg::iter_t  iter;

    qrd_num_pkg::sample_t mag;
    qrd_num_pkg::sample_t angle;
    qrd_num_pkg::sample_t a1_held;
    qrd_num_pkg::sample_t b1_held;
    logic                 vec_valid;

    qrd_ctrl u_ctrl (
        .clk    (clk),
        .rst_n  (rst_n),
        .load_o (load),
        .iter_o (iter),
        .gain_o (gain)
    );

    qrd_vector_cell u_vector (
        .clk     (clk),
        .rst_n   (rst_n),
        .load_i  (load),
        .gain_i  (gain),
        .iter_i  (iter),
        .a0_i    (a0_i),
        .b0_i    (b0_i),
        .a1_i    (a1_i),
        .b1_i    (b1_i),
        .valid_i (row_valid_i),
        .mag_o   (mag),
        .angle_o (angle),
        .a1_o    (a1_held),
        .b1_o    (b1_held),
        .valid_o (vec_valid)
    );

    qrd_rotate_cell u_rotate (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_i      (load),
        .gain_i      (gain),
        .iter_i      (iter),
        .mag_i       (mag),
        .angle_i     (angle),
        .x_i         (a1_held),
        .y_i         (b1_held),
        .valid_i     (vec_valid),
        .r00_o       (r00_o),
        .r01_o       (r01_o),
        .r11_o       (r11_o),
        .out_valid_o (out_valid_o)
    );

    assign in_ready_o = load;  // Inputs taken at every load edge

endmodule

`default_nettype wire

/* qrd_vector_cell.sv */
`default_nettype none

module qrd_vector_cell (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load_i,
    input  logic                 gain_i,
    input  qrd_ctrl_pkg::iter_t  iter_i,
    input  qrd_num_pkg::sample_t a0_i,
    input  qrd_num_pkg::sample_t b0_i,
    input  qrd_num_pkg::sample_t a1_i,
    input  qrd_num_pkg::sample_t b1_i,
    input  logic                 valid_i,
    output qrd_num_pkg::sample_t mag_o,
    output qrd_num_pkg::sample_t angle_o,
    output qrd_num_pkg::sample_t a1_o,
    output qrd_num_pkg::sample_t b1_o,
    output logic                 valid_o
);

    qrd_num_pkg::sample_t z_fin;

    qrd_cordic #(
        .VECTORING (1'b1)
    ) u_cordic (
        .clk    (clk),
        .load_i (load_i),
        .gain_i (gain_i),
        .iter_i (iter_i),
        .x_i    (a0_i),
        .y_i    (b0_i),
        .z_i    ('0),
        .x_o    (mag_o),
        .y_o    (),
        .z_o    (z_fin)
    );

    // Second column waits here while the angle is found
    always_ff @(posedge clk) begin
        if (load_i) begin
            a1_o <= a1_i;
            b1_o <= b1_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else if (load_i) begin
            valid_o <= valid_i;
        end
    end

    assign angle_o = -z_fin;  // Rotate cell turns back by the vector angle

endmodule

`default_nettype wire

/* tb_qrd.sv */
`default_nettype none

module tb_qrd;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_JOBS     = 2 + 7 + 20 + 12 + 6 + 8;
    localparam int TIMEOUT      = (NUM_JOBS + 3) * qrd_ctrl_pkg::FRAME_LEN + 3 * RESET_CYCLES;
    localparam int LATENCY      = 2 * qrd_ctrl_pkg::FRAME_LEN;

    logic                 clk;
    logic                 rst_n;
    qrd_num_pkg::sample_t a0, a1, b0, b1;
    logic                 row_valid;
    logic                 in_ready;
    logic                 out_valid;
    qrd_num_pkg::sample_t r00, r01, r11;

    int                   cyc;
    logic                 started;
    logic                 rst_seen;  // rst_n as seen by the last rising edge
    int                   phase;
    logic [15:0]          lfsr_state;
    string                test_name;

    qrd_num_pkg::sample_t exp_r00_q[$];
    qrd_num_pkg::sample_t exp_r01_q[$];
    qrd_num_pkg::sample_t exp_r11_q[$];
    int                   due_q[$];

    qrd_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .a0_i        (a0),
        .a1_i        (a1),
        .b0_i        (b0),
        .b1_i        (b1),
        .row_valid_i (row_valid),
        .in_ready_o  (in_ready),
        .out_valid_o (out_valid),
        .r00_o       (r00),
        .r01_o       (r01),
        .r11_o       (r11)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic fail_stop();
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_sample(input string name, input qrd_num_pkg::sample_t exp_v,
                                input qrd_num_pkg::sample_t act_v);
        if (act_v !== exp_v) begin
            $display("Error: %s expected %0d actual %0d", name, exp_v, act_v);
            fail_stop();
        end
    endtask

    task automatic check_flag(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("Error: %s expected %0b actual %0b", name, exp_v, act_v);
            fail_stop();
        end
    endtask

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic draw_bit();
        lfsr_state = lfsr_next(lfsr_state);
        return lfsr_state[0];
    endfunction

    function automatic qrd_num_pkg::sample_t draw_sample();
        logic [11:0]          raw;
        qrd_num_pkg::sample_t val;
        raw = '0;
        for (int i = 0; i < 12; i++) begin
            raw = {raw[10:0], draw_bit()};
        end
        val = qrd_num_pkg::sample_t'($signed(raw));
        if (val < -2047) begin
            val = -2047;  // Keep the range symmetric
        end
        return val;
    endfunction

    // Bit-true CORDIC, vectoring or rotation
    function automatic void cordic_ref(input bit vec, input qrd_num_pkg::sample_t x_in,
                                       input qrd_num_pkg::sample_t y_in,
                                       input qrd_num_pkg::sample_t z_in,
                                       output qrd_num_pkg::sample_t x_out,
                                       output qrd_num_pkg::sample_t y_out,
                                       output qrd_num_pkg::sample_t z_out);
        qrd_num_pkg::sample_t x, y, z, xs, ys;
        logic signed [27:0]   px, py;
        bit                   inv;
        bit                   go;
        bit                   dir;
        x   = x_in;
        y   = y_in;
        z   = z_in;
        inv = 0;
        if (vec) begin
            if (x_in < 0) begin
                x = -x_in;
                y = -y_in;
                z = (y_in >= 0) ? qrd_num_pkg::PI_Q : -qrd_num_pkg::PI_Q;
            end
        end else if (z_in > qrd_num_pkg::FOLD_LIMIT) begin
            z   = z_in - qrd_num_pkg::PI_Q;
            inv = 1;
        end else if (z_in < -qrd_num_pkg::FOLD_LIMIT - 1) begin
            z   = z_in + qrd_num_pkg::PI_Q;
            inv = 1;
        end
        for (int i = 0; i < qrd_ctrl_pkg::NUM_ITER; i++) begin
            go  = vec ? (y != 0) : (z != 0);
            dir = vec ? (y > 0) : (z < 0);
            xs  = x >>> i;
            ys  = y >>> i;
            if (go && dir) begin
                x = x + ys;
                y = y - xs;
                z = z + qrd_num_pkg::ATAN_TAB[i];
            end else if (go) begin
                x = x - ys;
                y = y + xs;
                z = z - qrd_num_pkg::ATAN_TAB[i];
            end
        end
        px    = x * qrd_num_pkg::GAIN_K;
        py    = y * qrd_num_pkg::GAIN_K;
        x_out = qrd_num_pkg::sample_t'(px >>> qrd_num_pkg::FRAC_BITS);
        y_out = qrd_num_pkg::sample_t'(py >>> qrd_num_pkg::FRAC_BITS);
        if (inv) begin
            x_out = -x_out;
            y_out = -y_out;
        end
        z_out = z;
    endfunction

    function automatic void qr_model(input qrd_num_pkg::sample_t a0_v, a1_v, b0_v, b1_v,
                                     output qrd_num_pkg::sample_t r00_v, r01_v, r11_v);
        qrd_num_pkg::sample_t unused_y, z_vec, unused_z;
        cordic_ref(1, a0_v, b0_v, '0, r00_v, unused_y, z_vec);
        cordic_ref(0, a1_v, b1_v, -z_vec, r01_v, r11_v, unused_z);
    endfunction

    // Cycle count and timeout
    always @(posedge clk) begin
        cyc      <= cyc + 1;
        started  <= 1'b1;
        rst_seen <= rst_n;
        if (cyc > TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
            fail_stop();
        end
    end

    // Compare process
    always @(negedge clk) begin
        logic exp_valid;
        if (started && !rst_seen) begin
            exp_r00_q.delete();
            exp_r01_q.delete();
            exp_r11_q.delete();
            due_q.delete();
            phase = 0;
            check_flag("reset in_ready", 1'b0, in_ready);
            check_flag("reset out_valid", 1'b0, out_valid);
        end else if (started) begin
            check_flag({test_name, " in_ready"}, phase == 0, in_ready);
            phase     = (phase == qrd_ctrl_pkg::FRAME_LEN - 1) ? 0 : phase + 1;
            exp_valid = (due_q.size() > 0) && (due_q[0] == cyc);
            check_flag({test_name, " out_valid"}, exp_valid, out_valid);
            if (exp_valid) begin
                check_sample({test_name, " r00"}, exp_r00_q.pop_front(), r00);
                check_sample({test_name, " r01"}, exp_r01_q.pop_front(), r01);
                check_sample({test_name, " r11"}, exp_r11_q.pop_front(), r11);
                void'(due_q.pop_front());
            end
        end
    end

    // Waits for the ready cycle and drives one job slot
    task automatic run_job(input qrd_num_pkg::sample_t a0_v, a1_v, b0_v, b1_v,
                           input logic valid_v);
        qrd_num_pkg::sample_t e00, e01, e11;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        a0        = a0_v;
        a1        = a1_v;
        b0        = b0_v;
        b1        = b1_v;
        row_valid = valid_v;
        if (valid_v) begin
            qr_model(a0_v, a1_v, b0_v, b1_v, e00, e01, e11);
            exp_r00_q.push_back(e00);
            exp_r01_q.push_back(e01);
            exp_r11_q.push_back(e11);
            due_q.push_back(cyc + LATENCY);
        end
    endtask

    task automatic random_job(input logic valid_v);
        qrd_num_pkg::sample_t s0, s1, s2, s3;
        s0 = draw_sample();
        s1 = draw_sample();
        s2 = draw_sample();
        s3 = draw_sample();
        run_job(s0, s1, s2, s3, valid_v);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n     = 1'b0;
        row_valid = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
    endtask

    initial begin
        rst_n      = 1'b0;
        a0         = '0;
        a1         = '0;
        b0         = '0;
        b1         = '0;
        row_valid  = 1'b0;
        cyc        = 0;
        started    = 1'b0;
        rst_seen   = 1'b0;
        phase      = 0;
        lfsr_state = 16'd56;
        test_name  = "reset";
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        test_name = "idle";
        run_job('0, '0, '0, '0, 1'b0);
        run_job('0, '0, '0, '0, 1'b0);

        test_name = "directed";
        run_job(14'sd1024, 14'sd300, 14'sd0, 14'sd500, 1'b1);     // On the x axis
        run_job(14'sd0, -14'sd700, 14'sd1024, 14'sd200, 1'b1);    // On the y axis
        run_job(14'sd900, 14'sd100, 14'sd0, -14'sd400, 1'b1);     // b0 zero
        run_job(-14'sd1024, 14'sd250, 14'sd512, 14'sd800, 1'b1);  // Quadrant fix, y positive
        run_job(-14'sd1024, -14'sd600, -14'sd512, 14'sd150, 1'b1);
        run_job(-14'sd1000, 14'sd1200, 14'sd0, -14'sd900, 1'b1);
        run_job(14'sd0, 14'sd333, 14'sd0, 14'sd444, 1'b1);        // Null vector

        test_name = "back_to_back";
        repeat (20) random_job(1'b1);

        test_name = "interleaved";
        for (int i = 0; i < 12; i++) begin
            random_job((i % 2 == 0) ? draw_bit() : 1'b0);
        end

        test_name = "mid_reset";
        repeat (6) random_job(1'b1);
        apply_reset();
        repeat (8) random_job(1'b1);

        test_name = "drain";
        @(negedge clk);
        row_valid = 1'b0;
        while (due_q.size() > 0) begin
            @(negedge clk);
        end
        repeat (2 * qrd_ctrl_pkg::FRAME_LEN) @(negedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
